// File: common/tileDriverPkg.sv
// Fixed four-core build; only core 0 is monitored and only the low 30 PC bits are compared
package tileDriverPkg;

  // ------------------------------------------------
  // Sizes and limits
  // ------------------------------------------------
  localparam int numCores    = 4;
  localparam int coreIdW     = 2;
  localparam int pcCmpW      = 30;   // Low PC bits used by the compare
  localparam int pcW         = 64;
  localparam int stuckLimit  = 500;  // Repeated valid PCs before stuck
  localparam int sleepDelay  = 20;   // Hit to sleep request, in cycles
  localparam int watchedCore = 0;
  localparam int beatW       = 64;
  localparam int laneCount   = 8;

  // ------------------------------------------------
  // Command and config words
  // ------------------------------------------------
  typedef enum logic [2:0] {
    opForceTile    = 3'd0,
    opReleaseTile  = 3'd1,
    opForceCore    = 3'd2,
    opReleaseCore  = 3'd3,
    opDisableStuck = 3'd4,  // Sticky until pcFail
    opSetFail      = 3'd5
  } cmdOpT;

  typedef struct packed {
    cmdOpT              op;
    logic [coreIdW-1:0] target;  // Ignored by the monitor commands
  } cmdT;

  typedef enum logic [1:0] {
    selPass    = 2'd0,
    selFail    = 2'd1,
    selPassAlt = 2'd2,
    selFailAlt = 2'd3
  } cfgSelT;

  typedef struct packed {
    cfgSelT            sel;
    logic [pcCmpW-1:0] data;
  } cfgWriteT;

  // Alternate slots are inactive while zero
  typedef struct packed {
    logic [pcCmpW-1:0] pass;
    logic [pcCmpW-1:0] fail;
    logic [pcCmpW-1:0] passAlt;
    logic [pcCmpW-1:0] failAlt;
  } pcAddrsT;

  typedef struct packed {
    logic           valid;
    logic [pcW-1:0] pc;
  } traceT;

  // ------------------------------------------------
  // Sub-word access
  // ------------------------------------------------
  typedef enum logic [1:0] {
    sz8  = 2'd0,
    sz16 = 2'd1,
    sz32 = 2'd2,
    sz64 = 2'd3
  } accSizeT;

  typedef struct packed {
    logic [2:0]       addr;  // Byte offset inside the beat
    accSizeT          size;
    logic [beatW-1:0] data;  // Write data, right aligned
  } laneAccT;

  // One beat seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [laneCount-1:0][7:0]    bytes;
    logic [laneCount/2-1:0][15:0] halves;
  } beatU;

endpackage

// File: rtl/flagRegs.sv
// Commands and config writes are single-cycle strobes with no handshake; unknown opcodes are dropped
`timescale 1ns/1ps

module flagRegs (
  input  logic                      clk,
  input  logic                      pcFail,
  input  logic                      cmdValid,
  input  tileDriverPkg::cmdT        cmd,
  input  logic                      cfgValid,
  input  tileDriverPkg::cfgWriteT   cfg,
  output logic                      forceTile,
  output logic                      releaseTile,
  output logic                      forceCore,
  output logic                      releaseCore,
  output logic [tileDriverPkg::coreIdW-1:0] target,
  output logic                      setFail,
  output logic                      stuckDisabled,
  output tileDriverPkg::pcAddrsT    pcAddrs
);

  import tileDriverPkg::*;

  // ------------------------------------------------
  // Self-clearing command pulses
  // ------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      forceTile   <= 1'b0;
      releaseTile <= 1'b0;
      forceCore   <= 1'b0;
      releaseCore <= 1'b0;
      setFail     <= 1'b0;
    end else begin
      forceTile   <= cmdValid && (cmd.op == opForceTile);
      releaseTile <= cmdValid && (cmd.op == opReleaseTile);
      forceCore   <= cmdValid && (cmd.op == opForceCore);
      releaseCore <= cmdValid && (cmd.op == opReleaseCore);
      setFail     <= cmdValid && (cmd.op == opSetFail);
    end
  end

  // Target rides alongside the pulses
  always_ff @(posedge clk) begin
    if (cmdValid) begin
      target <= cmd.target;
    end
  end

  // Once disabled the checker stays off
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      stuckDisabled <= 1'b0;
    end else if (cmdValid && (cmd.op == opDisableStuck)) begin
      stuckDisabled <= 1'b1;
    end
  end

  // ------------------------------------------------
  // Compare address slots
  // ------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      pcAddrs <= '0;
    end else if (cfgValid) begin
      case (cfg.sel)
        selPass:    pcAddrs.pass    <= cfg.data;
        selFail:    pcAddrs.fail    <= cfg.data;
        selPassAlt: pcAddrs.passAlt <= cfg.data;
        selFailAlt: pcAddrs.failAlt <= cfg.data;
      endcase
    end
  end

endmodule

// File: rtl/coreResetCtrl.sv
// Tiles leave pcFail held in reset and cores leave it running; sleep applies to the watched core only
`timescale 1ns/1ps

module coreResetCtrl (
  input  logic                                clk,
  input  logic                                pcFail,
  input  logic                                forceTile,
  input  logic                                releaseTile,
  input  logic                                forceCore,
  input  logic                                releaseCore,
  input  logic [tileDriverPkg::coreIdW-1:0]   target,
  input  logic                                sleepReq,
  output logic [tileDriverPkg::numCores-1:0]  tileReset,
  output logic [tileDriverPkg::numCores-1:0]  coreReset,
  output logic                                coreHeld
);

  import tileDriverPkg::*;

  // Tile reset bits, all held until released so memory can be loaded
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      tileReset <= '1;
    end else if (forceTile) begin
      tileReset[target] <= 1'b1;
    end else if (releaseTile) begin
      tileReset[target] <= 1'b0;
    end
  end

  // Core reset bits inside each tile
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      coreReset <= '0;
    end else begin
      if (forceCore) begin
        coreReset[target] <= 1'b1;
      end else if (releaseCore) begin
        coreReset[target] <= 1'b0;
      end
      // Sleep wins over a release in the same cycle
      if (sleepReq) begin
        coreReset[watchedCore] <= 1'b1;
      end
    end
  end

  assign coreHeld = coreReset[watchedCore];  // Back to the monitor

endmodule

// File: pcMonitor/stuckDetector.sv
// Compares the full 64-bit PC; invalid trace cycles neither count nor break a run of repeats
`timescale 1ns/1ps

module stuckDetector (
  input  logic                  clk,
  input  logic                  pcFail,
  input  tileDriverPkg::traceT  trace,
  input  logic                  stuckDisabled,
  output logic                  stuck
);

  import tileDriverPkg::*;

  typedef logic [$clog2(stuckLimit+1)-1:0] repCntT;

  logic [pcW-1:0] lastPc;
  repCntT         repCnt;
  repCntT         repCntNext;
  logic           stuckRaw;

  always_comb begin
    repCntNext = repCnt;
    if (trace.valid) begin
      if (trace.pc != lastPc) begin
        repCntNext = '0;
      end else if (repCnt != repCntT'(stuckLimit)) begin
        repCntNext = repCnt + repCntT'(1);  // Saturates at the limit
      end
    end
  end

  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      lastPc   <= '0;
      repCnt   <= '0;
      stuckRaw <= 1'b0;
    end else begin
      if (trace.valid) begin
        lastPc <= trace.pc;
      end
      repCnt   <= repCntNext;
      stuckRaw <= (repCntNext == repCntT'(stuckLimit));
    end
  end

  assign stuck = stuckRaw && !stuckDisabled;

endmodule

// File: pcMonitor/pcMonitor.sv
// Watches one core; status is sticky until pcFail and only the first hit arms the sleep countdown
`timescale 1ns/1ps

module pcMonitor (
  input  logic                     clk,
  input  logic                     pcFail,
  input  tileDriverPkg::traceT     trace,
  input  tileDriverPkg::pcAddrsT   pcAddrs,
  input  logic                     stuckDisabled,
  input  logic                     setFail,
  input  logic                     coreHeld,
  output logic                     passStatus,
  output logic                     failStatus,
  output logic                     stuck,
  output logic                     sleepReq
);

  import tileDriverPkg::*;

  typedef logic [$clog2(sleepDelay+1)-1:0] sleepCntT;

  logic              traceValidQ;
  logic [pcCmpW-1:0] tracePcQ;
  logic              passHit;
  logic              failHit;
  logic              anyHit;
  sleepCntT          sleepCnt;

  stuckDetector stuck0 (
    .clk           (clk),
    .pcFail        (pcFail),
    .trace         (trace),
    .stuckDisabled (stuckDisabled),
    .stuck         (stuck)
  );

  // ------------------------------------------------
  // Trace capture and address compare
  // ------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      traceValidQ <= 1'b0;
    end else begin
      traceValidQ <= trace.valid;
    end
  end

  always_ff @(posedge clk) begin
    tracePcQ <= trace.pc[pcCmpW-1:0];
  end

  always_comb begin
    passHit = traceValidQ &&
              ((tracePcQ == pcAddrs.pass) ||
               ((pcAddrs.passAlt != '0) && (tracePcQ == pcAddrs.passAlt)));
    failHit = stuck ||  // Stuck counts as a fail
              (traceValidQ &&
               ((tracePcQ == pcAddrs.fail) ||
                ((pcAddrs.failAlt != '0) && (tracePcQ == pcAddrs.failAlt))));
    anyHit  = (passHit || failHit) && !coreHeld;
  end

  // ------------------------------------------------
  // Status latch
  // ------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      passStatus <= 1'b0;
      failStatus <= 1'b0;
    end else if (setFail) begin
      passStatus <= 1'b0;
      failStatus <= 1'b1;
    end else if (anyHit) begin
      passStatus <= passStatus | passHit;
      failStatus <= failStatus | failHit;
    end
  end

  // Countdown to sleep, armed once by the first hit
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      sleepCnt <= '0;
      sleepReq <= 1'b0;
    end else begin
      sleepReq <= (sleepCnt == sleepCntT'(1));
      if (sleepCnt != '0) begin
        sleepCnt <= sleepCnt - sleepCntT'(1);
      end else if (anyHit && !passStatus && !failStatus && !stuckDisabled) begin
        sleepCnt <= sleepCntT'(sleepDelay);  // No sleep with checker off
      end
    end
  end

endmodule

// File: laneSteer/laneSteer.sv
// Purely combinational; addresses must be naturally aligned for their size, low bits are ignored
`timescale 1ns/1ps

module laneSteer (
  input  tileDriverPkg::laneAccT                acc,
  input  tileDriverPkg::beatU                   rdBeat,
  output logic [tileDriverPkg::laneCount-1:0]   wrMask,
  output tileDriverPkg::beatU                   wrBeat,
  output logic [tileDriverPkg::beatW-1:0]       rdData
);

  import tileDriverPkg::*;

  // ------------------------------------------------
  // Write side mask and replication
  // ------------------------------------------------
  always_comb begin
    wrBeat = '0;
    case (acc.size)
      sz8: begin
        wrMask = laneCount'(1) << acc.addr;
        for (int i = 0; i < laneCount; i++) begin
          wrBeat.bytes[i] = acc.data[7:0];
        end
      end
      sz16: begin
        wrMask = laneCount'(3) << {acc.addr[2:1], 1'b0};
        for (int i = 0; i < laneCount / 2; i++) begin
          wrBeat.halves[i] = acc.data[15:0];
        end
      end
      sz32: begin
        wrMask = acc.addr[2] ? 8'hF0 : 8'h0F;
        wrBeat = {2{acc.data[31:0]}};  // Word in both halves
      end
      default: begin
        wrMask = '1;
        wrBeat = acc.data;
      end
    endcase
  end

  // ------------------------------------------------
  // Read side extraction, zero extended
  // ------------------------------------------------
  always_comb begin
    case (acc.size)
      sz8:  rdData = beatW'(rdBeat.bytes[acc.addr]);
      sz16: rdData = beatW'(rdBeat.halves[acc.addr[2:1]]);
      sz32: begin
        if (acc.addr[2]) begin
          rdData = beatW'({rdBeat.halves[3], rdBeat.halves[2]});
        end else begin
          rdData = beatW'({rdBeat.halves[1], rdBeat.halves[0]});
        end
      end
      default: rdData = rdBeat;
    endcase
  end

endmodule

// File: rtl/tileDriverTop.sv
// Four cores with core 0 watched; no back-pressure, every strobe is taken in the cycle it arrives
`timescale 1ns/1ps

module tileDriverTop (
  input  logic                                clk,
  input  logic                                pcFail,
  input  logic                                cmdValid,
  input  tileDriverPkg::cmdT                  cmd,
  input  logic                                cfgValid,
  input  tileDriverPkg::cfgWriteT             cfg,
  input  tileDriverPkg::traceT                trace,
  input  tileDriverPkg::laneAccT              acc,
  input  tileDriverPkg::beatU                 rdBeat,
  output logic [tileDriverPkg::numCores-1:0]  tileReset,
  output logic [tileDriverPkg::numCores-1:0]  coreReset,
  output logic                                passStatus,
  output logic                                failStatus,
  output logic                                stuck,
  output logic [tileDriverPkg::laneCount-1:0] wrMask,
  output tileDriverPkg::beatU                 wrBeat,
  output logic [tileDriverPkg::beatW-1:0]     rdData
);

  import tileDriverPkg::*;

  logic               forceTile;
  logic               releaseTile;
  logic               forceCore;
  logic               releaseCore;
  logic [coreIdW-1:0] target;
  logic               setFail;
  logic               stuckDisabled;
  pcAddrsT            pcAddrs;
  logic               sleepReq;
  logic               coreHeld;

  flagRegs flags0 (
    .clk (clk), .pcFail (pcFail),
    .cmdValid (cmdValid), .cmd (cmd), .cfgValid (cfgValid), .cfg (cfg),
    .forceTile (forceTile), .releaseTile (releaseTile),
    .forceCore (forceCore), .releaseCore (releaseCore), .target (target),
    .setFail (setFail), .stuckDisabled (stuckDisabled), .pcAddrs (pcAddrs)
  );

  coreResetCtrl resetCtrl0 (
    .clk (clk), .pcFail (pcFail),
    .forceTile (forceTile), .releaseTile (releaseTile),
    .forceCore (forceCore), .releaseCore (releaseCore), .target (target),
    .sleepReq (sleepReq),
    .tileReset (tileReset), .coreReset (coreReset), .coreHeld (coreHeld)
  );

  pcMonitor monitor0 (
    .clk (clk), .pcFail (pcFail), .trace (trace), .pcAddrs (pcAddrs),
    .stuckDisabled (stuckDisabled), .setFail (setFail), .coreHeld (coreHeld),
    .passStatus (passStatus), .failStatus (failStatus), .stuck (stuck),
    .sleepReq (sleepReq)
  );

  laneSteer lanes0 (
    .acc (acc), .rdBeat (rdBeat),
    .wrMask (wrMask), .wrBeat (wrBeat), .rdData (rdData)
  );

endmodule

// File: tb/tbTests.svh
// Test tasks included into the testbench module; they rely on its signals and helper tasks

// --------------------------------------------------
// Reset outputs and tile release
// --------------------------------------------------
task automatic testResetAndTiles();
  string               name = "resetAndTiles";
  logic [numCores-1:0] expTile;
  startTest();
  if (tileReset !== 4'hF) reportMismatch(name, "tileReset after pcFail", 4'hF, tileReset);
  if (coreReset !== 4'h0) reportMismatch(name, "coreReset after pcFail", 4'h0, coreReset);
  expTile = '1;
  for (int t = 0; t < numCores; t++) begin
    sendCmd(opReleaseTile, coreIdW'(t));
    expTile[t] = 1'b0;
    if (tileReset !== expTile) reportMismatch(name, "tileReset release", expTile, tileReset);
  end
  for (int t = 0; t < numCores; t++) begin
    sendCmd(opForceTile, coreIdW'(t));
    expTile[t] = 1'b1;
    if (tileReset !== expTile) reportMismatch(name, "tileReset force", expTile, tileReset);
  end
  if (coreReset !== 4'h0) reportMismatch(name, "coreReset untouched", 4'h0, coreReset);
  endTest(name);
endtask

// Random force and release of core resets
task automatic testCoreResets();
  string               name = "coreResets";
  logic [numCores-1:0] expCore;
  logic [coreIdW-1:0]  tgt;
  startTest();
  expCore = '0;
  for (int i = 0; i < 12; i++) begin
    tgt = coreIdW'($urandom_range(numCores - 1));
    if ($urandom_range(1) == 1) begin
      sendCmd(opForceCore, tgt);
      expCore[tgt] = 1'b1;
    end else begin
      sendCmd(opReleaseCore, tgt);
      expCore[tgt] = 1'b0;
    end
    if (coreReset !== expCore) reportMismatch(name, "coreReset", expCore, coreReset);
    if (tileReset !== 4'hF) reportMismatch(name, "tileReset", 4'hF, tileReset);
  end
  endTest(name);
endtask

// --------------------------------------------------
// Pass and fail hits with sleep countdown
// --------------------------------------------------
task automatic testPassFail();
  string             name = "passFail";
  logic [pcCmpW-1:0] passAddr;
  logic [pcCmpW-1:0] failAddr;
  logic [pcCmpW-1:0] altAddr;
  logic [pcW-1:0]    pc;
  int                waited;
  startTest();
  applyReset();
  passAddr = {(pcCmpW-2)'($urandom), 2'b01};  // Low bits keep the slots apart
  failAddr = {(pcCmpW-2)'($urandom), 2'b10};
  altAddr  = {(pcCmpW-2)'($urandom), 2'b11};
  writeCfg(selPass, passAddr);
  writeCfg(selFail, failAddr);
  // Zero alternates must not match a zero PC
  pc = {$urandom, $urandom};
  pc[pcCmpW-1:0] = '0;
  driveTrace(pc);
  repeat (2) @(negedge clk);
  if (passStatus !== 1'b0) reportMismatch(name, "passStatus on zero PC", 0, passStatus);
  if (failStatus !== 1'b0) reportMismatch(name, "failStatus on zero PC", 0, failStatus);
  pc = {$urandom, $urandom};
  pc[pcCmpW-1:0] = passAddr;
  driveTrace(pc);
  @(negedge clk);
  if (passStatus !== 1'b1) reportMismatch(name, "passStatus", 1, passStatus);
  if (failStatus !== 1'b0) reportMismatch(name, "failStatus", 0, failStatus);
  countToSleep(sleepDelay + 10, waited);
  if (waited != sleepDelay + 1) reportMismatch(name, "cycles to sleep", sleepDelay + 1, waited);
  // Core is now asleep, so a fail hit is ignored
  pc[pcCmpW-1:0] = failAddr;
  driveTrace(pc);
  @(negedge clk);
  if (failStatus !== 1'b0) reportMismatch(name, "failStatus while held", 0, failStatus);
  sendCmd(opSetFail, '0);
  if (passStatus !== 1'b0) reportMismatch(name, "passStatus after setFail", 0, passStatus);
  if (failStatus !== 1'b1) reportMismatch(name, "failStatus after setFail", 1, failStatus);

  applyReset();
  writeCfg(selPass, passAddr);
  writeCfg(selFail, failAddr);
  writeCfg(selFailAlt, altAddr);
  pc = {$urandom, $urandom};
  pc[pcCmpW-1:0] = altAddr;
  driveTrace(pc);
  @(negedge clk);
  if (failStatus !== 1'b1) reportMismatch(name, "failStatus on alt", 1, failStatus);
  if (passStatus !== 1'b0) reportMismatch(name, "passStatus on alt", 0, passStatus);
  countToSleep(sleepDelay + 10, waited);
  if (waited != sleepDelay + 1) reportMismatch(name, "alt cycles to sleep", sleepDelay + 1, waited);
  endTest(name);
endtask

// --------------------------------------------------
// Stuck detection, then with the checker disabled
// --------------------------------------------------
task automatic testStuck();
  string             name = "stuck";
  logic [pcW-1:0]    pc;
  logic [pcCmpW-1:0] failAddr;
  int                waited;
  int                highCycles;
  startTest();
  applyReset();
  pc = {$urandom, $urandom};
  pc[0] = 1'b1;  // Clear of the zero pass and fail slots
  @(negedge clk);
  trace.valid = 1'b1;
  trace.pc    = pc;
  waited = 0;
  while (!stuck && waited < stuckLimit + 20) begin
    @(negedge clk);
    waited++;
  end
  // First PC is no repeat, so one extra cycle
  if (waited != stuckLimit + 1) reportMismatch(name, "cycles to stuck", stuckLimit + 1, waited);
  @(negedge clk);
  trace.valid = 1'b0;
  if (stuck !== 1'b1) reportMismatch(name, "stuck held", 1, stuck);
  if (failStatus !== 1'b1) reportMismatch(name, "failStatus from stuck", 1, failStatus);

  applyReset();
  sendCmd(opDisableStuck, '0);
  @(negedge clk);
  trace.valid = 1'b1;
  trace.pc    = pc;
  highCycles  = 0;
  repeat (stuckLimit + 10) begin
    @(negedge clk);
    if (stuck) highCycles++;
  end
  trace.valid = 1'b0;
  if (highCycles != 0) reportMismatch(name, "stuck cycles while disabled", 0, highCycles);
  if (failStatus !== 1'b0) reportMismatch(name, "failStatus while disabled", 0, failStatus);
  failAddr = {(pcCmpW-2)'($urandom), 2'b10};
  writeCfg(selFail, failAddr);
  pc[pcCmpW-1:0] = failAddr;
  driveTrace(pc);
  @(negedge clk);
  if (failStatus !== 1'b1) reportMismatch(name, "failStatus on hit", 1, failStatus);
  countToSleep(sleepDelay + 10, waited);
  if (coreReset[watchedCore] !== 1'b0) begin
    $display("%s: core 0 went to sleep although the stuck checker was disabled", name);
    errorCount++;
  end
  endTest(name);
endtask

// --------------------------------------------------
// Lane steering, combinational
// --------------------------------------------------
task automatic testLanes();
  string                name = "lanes";
  logic [laneCount-1:0] expMask;
  logic [beatW-1:0]     expWr;
  logic [beatW-1:0]     expRd;
  logic [beatW-1:0]     beat;
  int                   idx;
  startTest();
  for (int i = 0; i < 40; i++) begin
    @(negedge clk);
    acc.addr = 3'($urandom);
    acc.size = accSizeT'($urandom_range(3));
    acc.data = {$urandom, $urandom};
    beat     = {$urandom, $urandom};
    rdBeat   = beat;
    case (acc.size)
      sz8: begin
        expMask = 8'h01 << acc.addr;
        expWr   = {8{acc.data[7:0]}};
        expRd   = (beat >> (8 * acc.addr)) & 64'hFF;
      end
      sz16: begin
        idx     = acc.addr >> 1;  // Halfword index
        expMask = 8'h03 << (2 * idx);
        expWr   = {4{acc.data[15:0]}};
        expRd   = (beat >> (16 * idx)) & 64'hFFFF;
      end
      sz32: begin
        expMask = acc.addr[2] ? 8'hF0 : 8'h0F;
        expWr   = {2{acc.data[31:0]}};
        expRd   = acc.addr[2] ? (beat >> 32) : (beat & 64'hFFFF_FFFF);
      end
      default: begin
        expMask = 8'hFF;
        expWr   = acc.data;
        expRd   = beat;
      end
    endcase
    @(posedge clk);
    if (wrMask !== expMask) reportMismatch(name, "wrMask", expMask, wrMask);
    if (wrBeat !== expWr) reportMismatch(name, "wrBeat", expWr, wrBeat);
    if (rdData !== expRd) reportMismatch(name, "rdData", expRd, rdData);
  end
  endTest(name);
endtask

// File: tb/tbTileDriver.sv
// Directed tests for the fixed four-core build with core 0 watched; run is capped by a cycle limit
`timescale 1ns/1ps

module tbTileDriver;

  import tileDriverPkg::*;

  localparam int timeoutCycles = 3000;  // Tests need about 1250 cycles

  logic                 clk;
  logic                 pcFail;
  logic                 cmdValid;
  cmdT                  cmd;
  logic                 cfgValid;
  cfgWriteT             cfg;
  traceT                trace;
  laneAccT              acc;
  beatU                 rdBeat;
  logic [numCores-1:0]  tileReset;
  logic [numCores-1:0]  coreReset;
  logic                 passStatus;
  logic                 failStatus;
  logic                 stuck;
  logic [laneCount-1:0] wrMask;
  beatU                 wrBeat;
  logic [beatW-1:0]     rdData;

  int          errorCount;
  int          testStartErrors;
  int          testsRun;
  int          testsFailed;
  int          cycleCount;

  tileDriverTop dut0 (
    .clk (clk), .pcFail (pcFail),
    .cmdValid (cmdValid), .cmd (cmd), .cfgValid (cfgValid), .cfg (cfg),
    .trace (trace), .acc (acc), .rdBeat (rdBeat),
    .tileReset (tileReset), .coreReset (coreReset),
    .passStatus (passStatus), .failStatus (failStatus), .stuck (stuck),
    .wrMask (wrMask), .wrBeat (wrBeat), .rdData (rdData)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles, a test stopped making progress", cycleCount);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Bookkeeping
  // --------------------------------------------------
  task automatic reportMismatch(input string testName, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
    $display("CHECK FAILED %s %s expected %0h actual %0h", testName, what, expected, actual);
    errorCount++;
  endtask

  task automatic startTest();
    testStartErrors = errorCount;
  endtask

  task automatic endTest(input string testName);
    testsRun++;
    if (errorCount == testStartErrors) begin
      $display("%s: passed", testName);
    end else begin
      testsFailed++;
      $display("%s: %0d errors", testName, errorCount - testStartErrors);
    end
  endtask

  // --------------------------------------------------
  // Stimulus, all driven on falling edges
  // --------------------------------------------------
  task automatic applyReset();
    @(negedge clk);
    pcFail   = 1'b1;
    cmdValid = 1'b0;
    cfgValid = 1'b0;
    trace    = '0;
    repeat (2) @(negedge clk);
    pcFail = 1'b0;
  endtask

  // Returns once the reset outputs reflect the command
  task automatic sendCmd(input cmdOpT op, input logic [coreIdW-1:0] tgt);
    @(negedge clk);
    cmdValid   = 1'b1;
    cmd.op     = op;
    cmd.target = tgt;
    @(negedge clk);
    cmdValid = 1'b0;
    @(negedge clk);  // Pulse edge, then state edge
  endtask

  task automatic writeCfg(input cfgSelT sel, input logic [pcCmpW-1:0] data);
    @(negedge clk);
    cfgValid = 1'b1;
    cfg.sel  = sel;
    cfg.data = data;
    @(negedge clk);
    cfgValid = 1'b0;
  endtask

  // One valid trace cycle; it has been sampled on return
  task automatic driveTrace(input logic [pcW-1:0] pc);
    @(negedge clk);
    trace.valid = 1'b1;
    trace.pc    = pc;
    @(negedge clk);
    trace.valid = 1'b0;
  endtask

  task automatic countToSleep(input int limit, output int cycles);
    cycles = 0;
    while (!coreReset[watchedCore] && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  `include "tbTests.svh"

  initial begin
    clk        = 1'b0;
    pcFail     = 1'b1;
    cmdValid   = 1'b0;
    cmd        = '0;
    cfgValid   = 1'b0;
    cfg        = '0;
    trace      = '0;
    acc        = '0;
    rdBeat     = '0;
    errorCount = 0;
    testsRun   = 0;
    testsFailed = 0;
    cycleCount = 0;
    void'($urandom(32'hba90));
    applyReset();
    testResetAndTiles();
    testCoreResets();
    testPassFail();
    testStuck();
    testLanes();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tileDriver.f
+incdir+tb
common/tileDriverPkg.sv
rtl/flagRegs.sv
rtl/coreResetCtrl.sv
pcMonitor/stuckDetector.sv
pcMonitor/pcMonitor.sv
laneSteer/laneSteer.sv
rtl/tileDriverTop.sv
tb/tbTileDriver.sv
